// ==== Bender.yml ====
package:
  name: rx_frontend

sources:
  - include_dirs:
      - design
    files:
      - design/rx_fe_pkg.sv
      - design/rx_fe_settings.sv
      - design/rx_iq_map.sv
      - design/rx_dc_offset.sv
      - design/rx_iq_comp.sv
      - design/rx_round.sv
      - design/rx_frontend.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - tb/tb_rx_frontend.sv

// ==== design/rx_dc_offset.sv ====
// DC offset stage, adds a signed offset to each channel with saturation
`timescale 1ns/1ns
`include "rx_fe_defs.svh"

module rx_dc_offset import rx_fe_pkg::*; (
  input  logic                           clk,
  input  logic                           reset,
  input  rx_fe_sample_t                  smp_i,
  input  logic signed [`RX_FE_DSP_W-1:0] ofs_i_i,
  input  logic signed [`RX_FE_DSP_W-1:0] ofs_q_i,
  output rx_fe_sample_t                  smp_o
);

  localparam int unsigned W = `RX_FE_DSP_W;

  // Clip a W+1 bit sum back into W bits
  function automatic logic signed [W-1:0] sat_sum(input logic signed [W:0] x);
    logic signed [W-1:0] y;
    if (x[W] != x[W-1]) begin
      // Overflow, pick the rail on the side of the true sign
      y = x[W] ? {1'b1, {(W-1){1'b0}}} : {1'b0, {(W-1){1'b1}}};
    end else begin
      y = x[W-1:0];
    end
    return y;
  endfunction

  logic signed [W:0]   sum_i;
  logic signed [W:0]   sum_q;

  logic                strb_r;
  logic signed [W-1:0] i_r;
  logic signed [W-1:0] q_r;

  // One extra bit so the add itself can never wrap
  always_comb begin
    sum_i = smp_i.i + ofs_i_i;
    sum_q = smp_i.q + ofs_q_i;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      strb_r <= 1'b0;
    end else begin
      strb_r <= smp_i.strb;
    end
  end

  always_ff @(posedge clk) begin
    i_r <= sat_sum(sum_i);
    q_r <= sat_sum(sum_q);
  end

  assign smp_o = '{strb: strb_r, i: i_r, q: q_r};

endmodule

// ==== design/rx_fe_defs.svh ====
// RX front end settings addresses and datapath widths
`ifndef RX_FE_DEFS_SVH
`define RX_FE_DEFS_SVH

// Settings bus register addresses
`define RX_FE_SR_MAG    8'd0
`define RX_FE_SR_PHASE  8'd1
`define RX_FE_SR_OFS_I  8'd2
`define RX_FE_SR_OFS_Q  8'd3
`define RX_FE_SR_MAP    8'd4

// ADC input and rounded output width
`define RX_FE_ADC_W     16

// Internal datapath width, Q1.23
`define RX_FE_DSP_W     24

// Imbalance correction coefficients, Q1.17
`define RX_FE_COEF_W    18

// Settings bus widths
`define RX_FE_SET_AW    8
`define RX_FE_SET_DW    32

`endif

// ==== design/rx_fe_pkg.sv ====
// RX front end types for in-flight samples, corrections and settings words
`include "rx_fe_defs.svh"

package rx_fe_pkg;

  // One sample moving between pipeline stages
  typedef struct packed {
    logic                           strb;
    logic signed [`RX_FE_DSP_W-1:0] i;
    logic signed [`RX_FE_DSP_W-1:0] q;
  } rx_fe_sample_t;

  // I/Q mapping flags
  typedef struct packed {
    logic bypass_all;
    logic invert_i;
    logic invert_q;
    logic realmode;
    logic swap_iq;
  } rx_fe_map_t;

  // Correction values, mag and phase are Q1.17
  typedef struct packed {
    logic signed [`RX_FE_COEF_W-1:0] mag;
    logic signed [`RX_FE_COEF_W-1:0] phase;
    logic signed [`RX_FE_DSP_W-1:0]  ofs_i;
    logic signed [`RX_FE_DSP_W-1:0]  ofs_q;
  } rx_fe_corr_t;

  // Settings data word, read as a coefficient or as mapping flags
  typedef union packed {
    logic [`RX_FE_SET_DW-1:0] raw;
    struct packed {
      logic [23:0] rsvd_hi;
      logic        bypass_all;
      logic [1:0]  rsvd_mid;
      logic        invert_i;
      logic        invert_q;
      logic        rsvd_lo;
      logic        realmode;
      logic        swap_iq;
    } map;
  } rx_fe_set_word_u;

endpackage

// ==== design/rx_fe_settings.sv ====
// RX front end settings bank, decodes bus writes into mapping flags and corrections
`timescale 1ns/1ns
`include "rx_fe_defs.svh"

module rx_fe_settings import rx_fe_pkg::*; (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      set_stb_i,
  input  logic [`RX_FE_SET_AW-1:0]  set_addr_i,
  input  rx_fe_set_word_u           set_data_i,
  output rx_fe_map_t                map_o,
  output rx_fe_corr_t               corr_o
);

  rx_fe_map_t  map_r;
  rx_fe_corr_t corr_r;

  // Flags pulled out of the map view of the data word
  rx_fe_map_t  map_wr;

  always_comb begin
    map_wr.bypass_all = set_data_i.map.bypass_all;
    map_wr.invert_i   = set_data_i.map.invert_i;
    map_wr.invert_q   = set_data_i.map.invert_q;
    map_wr.realmode   = set_data_i.map.realmode;
    map_wr.swap_iq    = set_data_i.map.swap_iq;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      map_r  <= '0;
      corr_r <= '0;
    end else if (set_stb_i) begin
      case (set_addr_i)
        `RX_FE_SR_MAG: begin
          corr_r.mag <= set_data_i.raw[`RX_FE_COEF_W-1:0];
        end
        `RX_FE_SR_PHASE: begin
          corr_r.phase <= set_data_i.raw[`RX_FE_COEF_W-1:0];
        end
        `RX_FE_SR_OFS_I: begin
          corr_r.ofs_i <= set_data_i.raw[`RX_FE_DSP_W-1:0];
        end
        `RX_FE_SR_OFS_Q: begin
          corr_r.ofs_q <= set_data_i.raw[`RX_FE_DSP_W-1:0];
        end
        `RX_FE_SR_MAP: begin
          map_r <= map_wr;
        end
        default: begin
          // Addresses outside the bank are ignored
        end
      endcase
    end
  end

  assign map_o  = map_r;
  assign corr_o = corr_r;

endmodule

// ==== design/rx_frontend.sv ====
// RX front end top, settings bank and four-stage I/Q pipeline with raw bypass
`timescale 1ns/1ns
`include "rx_fe_defs.svh"

module rx_frontend import rx_fe_pkg::*; (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     set_stb_i,
  input  logic [`RX_FE_SET_AW-1:0] set_addr_i,
  input  logic [`RX_FE_SET_DW-1:0] set_data_i,
  input  logic                     adc_stb_i,
  input  logic [`RX_FE_ADC_W-1:0]  adc_i_i,
  input  logic [`RX_FE_ADC_W-1:0]  adc_q_i,
  output logic                     rx_stb_o,
  output logic [`RX_FE_ADC_W-1:0]  rx_i_o,
  output logic [`RX_FE_ADC_W-1:0]  rx_q_o
);

  rx_fe_map_t                     map;
  rx_fe_corr_t                    corr;
  rx_fe_sample_t                  smp_map;
  rx_fe_sample_t                  smp_ofs;
  rx_fe_sample_t                  smp_comp;
  logic signed [`RX_FE_ADC_W-1:0] rnd_i;
  logic signed [`RX_FE_ADC_W-1:0] rnd_q;

  rx_fe_settings rx_fe_settings_i (
    .clk        (clk),
    .reset      (reset),
    .set_stb_i  (set_stb_i),
    .set_addr_i (set_addr_i),
    .set_data_i (set_data_i),
    .map_o      (map),
    .corr_o     (corr)
  );

  rx_iq_map rx_iq_map_i (
    .clk       (clk),
    .reset     (reset),
    .adc_stb_i (adc_stb_i),
    .adc_i_i   (adc_i_i),
    .adc_q_i   (adc_q_i),
    .map_i     (map),
    .smp_o     (smp_map)
  );

  rx_dc_offset rx_dc_offset_i (
    .clk     (clk),
    .reset   (reset),
    .smp_i   (smp_map),
    .ofs_i_i (corr.ofs_i),
    .ofs_q_i (corr.ofs_q),
    .smp_o   (smp_ofs)
  );

  rx_iq_comp rx_iq_comp_i (
    .clk     (clk),
    .reset   (reset),
    .smp_i   (smp_ofs),
    .mag_i   (corr.mag),
    .phase_i (corr.phase),
    .smp_o   (smp_comp)
  );

  rx_round rx_round_i (
    .clk      (clk),
    .reset    (reset),
    .smp_i    (smp_comp),
    .rx_stb_o (rx_stb_o),
    .rx_i_o   (rnd_i),
    .rx_q_o   (rnd_q)
  );

  // Raw ADC words skip the whole pipeline, the strobe does not
  assign rx_i_o = map.bypass_all ? adc_i_i : rnd_i;
  assign rx_q_o = map.bypass_all ? adc_q_i : rnd_q;

endmodule

// ==== design/rx_iq_comp.sv ====
// I/Q imbalance stage, two-cycle multiply-add-clip for magnitude and phase
`timescale 1ns/1ns
`include "rx_fe_defs.svh"

module rx_iq_comp import rx_fe_pkg::*; (
  input  logic                            clk,
  input  logic                            reset,
  input  rx_fe_sample_t                   smp_i,
  input  logic signed [`RX_FE_COEF_W-1:0] mag_i,
  input  logic signed [`RX_FE_COEF_W-1:0] phase_i,
  output rx_fe_sample_t                   smp_o
);

  localparam int unsigned W  = `RX_FE_DSP_W;
  localparam int unsigned CW = `RX_FE_COEF_W;
  localparam int unsigned PW = 2 * CW;
  // Q2.34 product realigned to the Q1.23 datapath
  localparam int unsigned SH = PW - 1 - W;

  // Clip a W+2 bit sum into W bits
  function automatic logic signed [W-1:0] sat_sum(input logic signed [W+1:0] x);
    logic signed [W-1:0] y;
    if (x > $signed({{3{1'b0}}, {(W-1){1'b1}}})) begin
      y = {1'b0, {(W-1){1'b1}}};
    end else if (x < $signed({{3{1'b1}}, {(W-1){1'b0}}})) begin
      y = {1'b1, {(W-1){1'b0}}};
    end else begin
      y = x[W-1:0];
    end
    return y;
  endfunction

  logic signed [CW-1:0] i_top;

  logic signed [PW-1:0] prod_mag_r;
  logic signed [PW-1:0] prod_phase_r;
  logic signed [W-1:0]  i_d;
  logic signed [W-1:0]  q_d;

  logic signed [W:0]    adj_mag;
  logic signed [W:0]    adj_phase;
  logic signed [W+1:0]  sum_i;
  logic signed [W+1:0]  sum_q;

  logic [1:0]           strb_d;
  logic signed [W-1:0]  i_r;
  logic signed [W-1:0]  q_r;

  assign i_top = smp_i.i[W-1:W-CW];

  // Cycle one, both products come from I
  always_ff @(posedge clk) begin
    prod_mag_r   <= i_top * mag_i;
    prod_phase_r <= i_top * phase_i;
    i_d          <= smp_i.i;
    q_d          <= smp_i.q;
  end

  // Cycle two, arithmetic shift is just the upper product bits
  always_comb begin
    adj_mag   = prod_mag_r[PW-1:SH];
    adj_phase = prod_phase_r[PW-1:SH];
    sum_i     = i_d + adj_mag;
    sum_q     = q_d + adj_phase;
  end

  always_ff @(posedge clk) begin
    i_r <= sat_sum(sum_i);
    q_r <= sat_sum(sum_q);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      strb_d <= 2'b00;
    end else begin
      strb_d <= {strb_d[0], smp_i.strb};
    end
  end

  assign smp_o = '{strb: strb_d[1], i: i_r, q: q_r};

endmodule

// ==== design/rx_iq_map.sv ====
// I/Q mapping stage, swaps, inverts and zeroes channels and widens them to 24 bits
`timescale 1ns/1ns
`include "rx_fe_defs.svh"

module rx_iq_map import rx_fe_pkg::*; (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     adc_stb_i,
  input  logic [`RX_FE_ADC_W-1:0]  adc_i_i,
  input  logic [`RX_FE_ADC_W-1:0]  adc_q_i,
  input  rx_fe_map_t               map_i,
  output rx_fe_sample_t            smp_o
);

  logic [`RX_FE_ADC_W-1:0] src_i;
  logic [`RX_FE_ADC_W-1:0] src_q;
  logic [`RX_FE_ADC_W-1:0] adc_i_inv;
  logic [`RX_FE_ADC_W-1:0] adc_q_inv;

  logic                    strb_r;
  logic [`RX_FE_DSP_W-1:0] i_r;
  logic [`RX_FE_DSP_W-1:0] q_r;

  // Inversion flags stay tied to their ADC input, not to the output channel
  assign adc_i_inv = map_i.invert_i ? ~adc_i_i : adc_i_i;
  assign adc_q_inv = map_i.invert_q ? ~adc_q_i : adc_q_i;

  always_comb begin
    src_i = map_i.swap_iq ? adc_q_inv : adc_i_inv;
    src_q = map_i.swap_iq ? adc_i_inv : adc_q_inv;
    if (map_i.realmode) begin
      src_q = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      strb_r <= 1'b0;
    end else begin
      strb_r <= adc_stb_i;
    end
  end

  // ADC word lands in the top bits, zero fill below
  always_ff @(posedge clk) begin
    i_r <= {src_i, 8'd0};
    q_r <= {src_q, 8'd0};
  end

  assign smp_o = '{strb: strb_r, i: i_r, q: q_r};

endmodule

// ==== design/rx_round.sv ====
// Rounding stage, error-feedback rounding of each channel from 24 to 16 bits
`timescale 1ns/1ns
`include "rx_fe_defs.svh"

module rx_round import rx_fe_pkg::*; (
  input  logic                           clk,
  input  logic                           reset,
  input  rx_fe_sample_t                  smp_i,
  output logic                           rx_stb_o,
  output logic signed [`RX_FE_ADC_W-1:0] rx_i_o,
  output logic signed [`RX_FE_ADC_W-1:0] rx_q_o
);

  localparam int unsigned IW = `RX_FE_DSP_W;
  localparam int unsigned OW = `RX_FE_ADC_W;
  localparam int unsigned DW = IW - OW;
  // Residue stays within half an output LSB either way
  localparam int unsigned EW = DW + 1;
  localparam int unsigned SW = IW + 2;

  // One channel, returns the rounded word and the next residue
  task automatic round_ch(input  logic signed [IW-1:0] x,
                          input  logic signed [EW-1:0] err,
                          output logic signed [OW-1:0] y,
                          output logic signed [EW-1:0] err_n);
    logic signed [SW-1:0] sum;
    logic signed [SW-1:0] res;
    sum = x + err;
    res = (sum + SW'(1 << (DW - 1))) >>> DW;
    if (res > $signed(SW'((1 << (OW - 1)) - 1))) begin
      y     = {1'b0, {(OW-1){1'b1}}};
      err_n = '0;
    end else if (res < -$signed(SW'(1 << (OW - 1)))) begin
      y     = {1'b1, {(OW-1){1'b0}}};
      err_n = '0;
    end else begin
      y     = res[OW-1:0];
      err_n = EW'(sum - (res <<< DW));
    end
  endtask

  logic signed [EW-1:0] err_i_r, err_q_r;
  logic signed [EW-1:0] err_i_n, err_q_n;
  logic signed [OW-1:0] y_i, y_q;

  always_comb begin
    round_ch(smp_i.i, err_i_r, y_i, err_i_n);
    round_ch(smp_i.q, err_q_r, y_q, err_q_n);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rx_stb_o <= 1'b0;
      err_i_r  <= '0;
      err_q_r  <= '0;
    end else begin
      rx_stb_o <= smp_i.strb;
      if (smp_i.strb) begin
        err_i_r <= err_i_n;
        err_q_r <= err_q_n;
      end
    end
  end

  // Output words hold between strobes
  always_ff @(posedge clk) begin
    if (smp_i.strb) begin
      rx_i_o <= y_i;
      rx_q_o <= y_q;
    end
  end

endmodule

// ==== filelist.f ====
+incdir+design
design/rx_fe_pkg.sv
design/rx_fe_settings.sv
design/rx_iq_map.sv
design/rx_dc_offset.sv
design/rx_iq_comp.sv
design/rx_round.sv
design/rx_frontend.sv
tb/tb_rx_frontend.sv

// ==== tb/tb_rx_frontend.sv ====
// Testbench for the RX front end, directed tests checked against a reference model
`timescale 1ns/1ns
`include "rx_fe_defs.svh"

module tb_rx_frontend;

  // Rough cycle count of reset plus the six tests
  localparam int TEST_CYCLES = 16 + 70 + 180 + 40 + 50 + 110 + 30;
  localparam int CYCLE_LIMIT = 2 * TEST_CYCLES + 100;

  logic        clk = 1'b0;
  logic        reset;
  logic        set_stb_i;
  logic [7:0]  set_addr_i;
  logic [31:0] set_data_i;
  logic        adc_stb_i;
  logic [15:0] adc_i_i;
  logic [15:0] adc_q_i;
  logic        rx_stb_o;
  logic [15:0] rx_i_o;
  logic [15:0] rx_q_o;

  integer seed = 36;
  int     cyc = 0;
  string  cur_test = "reset";

  // Model copy of the settings registers and rounding residues
  bit m_inv_i, m_inv_q, m_real, m_swap;
  int m_ofs_i, m_ofs_q, m_mag, m_phase;
  int res_i, res_q;

  logic [31:0] exp_q[$];
  int          issue_q[$];
  logic [31:0] out_exp;
  int          out_issue;

  rx_frontend rx_frontend_i (
    .clk        (clk),
    .reset      (reset),
    .set_stb_i  (set_stb_i),
    .set_addr_i (set_addr_i),
    .set_data_i (set_data_i),
    .adc_stb_i  (adc_stb_i),
    .adc_i_i    (adc_i_i),
    .adc_q_i    (adc_q_i),
    .rx_stb_o   (rx_stb_o),
    .rx_i_o     (rx_i_o),
    .rx_q_o     (rx_q_o)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= CYCLE_LIMIT) begin
      $display("Timeout, the simulation hung after %0d cycles", cyc);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  end

  task automatic check_eq(input string label, input logic [31:0] exp_v,
                          input logic [31:0] act_v);
    assert (exp_v === act_v) else begin
      $display("Error in %s, %s: expected %h, actual %h", cur_test, label, exp_v, act_v);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  endtask

  function automatic int clip24(input longint x);
    if (x > 8388607) return 8388607;
    if (x < -8388608) return -8388608;
    return int'(x);
  endfunction

  // Error-feedback rounding of one channel, residue cleared on saturation
  function automatic int round_ch(input int x, input int e_in, output int e_out);
    int s;
    int r;
    s = x + e_in;
    r = (s + 128) >>> 8;
    e_out = 0;
    if (r > 32767) return 32767;
    if (r < -32768) return -32768;
    e_out = s - r * 256;
    return r;
  endfunction

  function automatic logic [31:0] model_sample(input logic [15:0] ai, input logic [15:0] aq);
    logic [15:0] a_i;
    logic [15:0] a_q;
    logic [15:0] m_i;
    logic [15:0] m_q;
    int          xi;
    int          xq;
    longint      adj_m;
    longint      adj_p;
    int          yi;
    int          yq;
    // Inversion stays with the ADC input, swap then picks the channel
    a_i = m_inv_i ? ~ai : ai;
    a_q = m_inv_q ? ~aq : aq;
    m_i = m_swap ? a_q : a_i;
    m_q = m_swap ? a_i : a_q;
    if (m_real) m_q = '0;
    xi = clip24(longint'($signed(m_i)) * 256 + m_ofs_i);
    xq = clip24(longint'($signed(m_q)) * 256 + m_ofs_q);
    // Both imbalance terms come from the top 18 bits of I
    adj_m = (longint'(xi >>> 6) * m_mag) >>> 11;
    adj_p = (longint'(xi >>> 6) * m_phase) >>> 11;
    xq = clip24(xq + adj_p);
    xi = clip24(xi + adj_m);
    yi = round_ch(xi, res_i, res_i);
    yq = round_ch(xq, res_q, res_q);
    return {yi[15:0], yq[15:0]};
  endfunction

  // Output monitor, one expected result per output strobe
  always @(negedge clk) begin
    if (!reset && rx_stb_o) begin
      assert (exp_q.size() != 0) else begin
        $display("An output strobe came with no input sample in flight");
        $display("SIMULATION FAILED");
        $fatal(1);
      end
      out_exp   = exp_q.pop_front();
      out_issue = issue_q.pop_front();
      check_eq("strobe latency", 32'(out_issue + 5), 32'(cyc));
      check_eq("rx i/q", out_exp, {rx_i_o, rx_q_o});
    end
  end

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    set_stb_i  = 1'b1;
    set_addr_i = addr;
    set_data_i = data;
    case (addr)
      `RX_FE_SR_MAG:   m_mag   = $signed(data[17:0]);
      `RX_FE_SR_PHASE: m_phase = $signed(data[17:0]);
      `RX_FE_SR_OFS_I: m_ofs_i = $signed(data[23:0]);
      `RX_FE_SR_OFS_Q: m_ofs_q = $signed(data[23:0]);
      `RX_FE_SR_MAP: begin
        m_inv_i = data[4];
        m_inv_q = data[3];
        m_real  = data[1];
        m_swap  = data[0];
      end
      default: ;
    endcase
    @(negedge clk);
    set_stb_i = 1'b0;
  endtask

  task automatic write_map(input logic byp, input logic inv_i, input logic inv_q,
                           input logic realm, input logic swp);
    write_reg(`RX_FE_SR_MAP, {24'd0, byp, 2'b00, inv_i, inv_q, 1'b0, realm, swp});
  endtask

  task automatic send_sample(input logic [15:0] ai, input logic [15:0] aq);
    adc_stb_i = 1'b1;
    adc_i_i   = ai;
    adc_q_i   = aq;
    exp_q.push_back(model_sample(ai, aq));
    issue_q.push_back(cyc);
    @(negedge clk);
    adc_stb_i = 1'b0;
  endtask

  // Wait until every issued sample has come out
  task automatic drain();
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (2) @(negedge clk);
  endtask

  task automatic reset_defaults();
    int gap;
    cur_test = "reset_defaults";
    repeat (3) begin
      check_eq("strobe after reset", 32'd0, {31'd0, rx_stb_o});
      @(negedge clk);
    end
    for (int n = 0; n < 20; n++) begin
      send_sample(16'($random(seed)), 16'($random(seed)));
      gap = $unsigned($random(seed)) % 3;
      repeat (gap) @(negedge clk);
    end
    drain();
  endtask

  task automatic iq_mapping();
    cur_test = "iq_mapping";
    for (int m = 0; m < 16; m++) begin
      write_map(1'b0, m[3], m[2], m[1], m[0]);
      send_sample(16'($random(seed)), 16'($random(seed)));
      send_sample(16'h8000, 16'h7FFF);
      drain();
    end
    write_map(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic dc_offset_clip();
    cur_test = "dc_offset_clip";
    write_reg(`RX_FE_SR_OFS_I, 32'h003F_0000);
    write_reg(`RX_FE_SR_OFS_Q, 32'hFFC1_0000);
    send_sample(16'h7000, 16'h9000);
    send_sample(16'h7FFF, 16'h8000);
    send_sample(16'h0100, 16'hFF00);
    send_sample(16'($random(seed)), 16'($random(seed)));
    drain();
    write_reg(`RX_FE_SR_OFS_I, 32'hFFED_CBAA);
    write_reg(`RX_FE_SR_OFS_Q, 32'h002A_0000);
    send_sample(16'h8000, 16'h7FFF);
    send_sample(16'($random(seed)), 16'($random(seed)));
    drain();
    write_reg(`RX_FE_SR_OFS_I, 32'd0);
    write_reg(`RX_FE_SR_OFS_Q, 32'd0);
  endtask

  task automatic imbalance_comp();
    int mags[3]   = '{32'h0001_0000, -131072, -16384};
    int phases[3] = '{32'h0000_8000, 131071, -131071};
    cur_test = "imbalance_comp";
    for (int k = 0; k < 3; k++) begin
      write_reg(`RX_FE_SR_MAG, 32'(mags[k]));
      write_reg(`RX_FE_SR_PHASE, 32'(phases[k]));
      send_sample(16'h7FFF, 16'h1234);
      send_sample(16'h8000, 16'h0000);
      send_sample(16'hC000, 16'h4000);
      send_sample(16'($random(seed)), 16'($random(seed)));
      drain();
    end
    write_reg(`RX_FE_SR_MAG, 32'd0);
    write_reg(`RX_FE_SR_PHASE, 32'd0);
  endtask

  task automatic streaming();
    int gap;
    cur_test = "streaming";
    write_reg(`RX_FE_SR_MAG, 32'h0000_3000);
    for (int n = 0; n < 30; n++) begin
      // Map change lands while earlier samples are still in flight
      if (n == 15) write_map(1'b0, 1'b1, 1'b0, 1'b0, 1'b1);
      send_sample(16'($random(seed)), 16'($random(seed)));
      if (n >= 10) begin
        gap = $unsigned($random(seed)) % 3;
        repeat (gap) @(negedge clk);
      end
    end
    drain();
    write_map(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    write_reg(`RX_FE_SR_MAG, 32'd0);
  endtask

  task automatic raw_bypass();
    logic [15:0] ri;
    logic [15:0] rq;
    cur_test = "raw_bypass";
    write_map(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    for (int n = 0; n < 10; n++) begin
      ri      = 16'($random(seed));
      rq      = 16'($random(seed));
      adc_i_i = ri;
      adc_q_i = rq;
      #2;
      check_eq("bypass i/q", {ri, rq}, {rx_i_o, rx_q_o});
      @(negedge clk);
    end
    write_map(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    repeat (4) send_sample(16'($random(seed)), 16'($random(seed)));
    drain();
  endtask

  initial begin
    reset      = 1'b1;
    set_stb_i  = 1'b0;
    set_addr_i = '0;
    set_data_i = '0;
    adc_stb_i  = 1'b0;
    adc_i_i    = '0;
    adc_q_i    = '0;
    repeat (16) @(negedge clk);
    reset = 1'b0;
    reset_defaults();
    iq_mapping();
    dc_offset_clip();
    imbalance_comp();
    streaming();
    raw_bypass();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule
